/* logic/issue_pkg.sv */
package issue_pkg;

    localparam int data_width  = 16;
    localparam int tag_width   = 4;
    localparam int num_regs    = 8;
    localparam int reg_width   = 3;
    localparam int rs_depth    = 4;
    localparam int mult_stages = 3;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul
    } op_t;

    // a source is either a value or the tag of the instruction that will produce it
    typedef struct packed {
        logic                  ready;
        logic [tag_width-1:0]  tag;
        logic [data_width-1:0] value;
    } operand_t;

    typedef struct packed {
        op_t                  op;
        logic [reg_width-1:0] dest;
        logic [reg_width-1:0] src1;
        logic [reg_width-1:0] src2;
    } instr_t;

    typedef struct packed {
        logic                 valid;
        op_t                  op;
        logic [reg_width-1:0] dest;
        logic [tag_width-1:0] tag;
        operand_t             src1;
        operand_t             src2;
    } rs_entry_t;

    typedef struct packed {
        logic                  valid;
        op_t                   op;
        logic [reg_width-1:0]  dest;
        logic [tag_width-1:0]  tag;
        logic [data_width-1:0] src1_value;
        logic [data_width-1:0] src2_value;
    } exec_op_t;

    function automatic logic [data_width-1:0] reg_reset_value(input int index);
        return data_width'(index * 16'h0111);
    endfunction

    // capture a broadcast result into a waiting source
    function automatic operand_t wake_operand(
        input operand_t              src,
        input logic                  bus_valid,
        input logic [tag_width-1:0]  bus_tag,
        input logic [data_width-1:0] bus_value
    );
        operand_t woken;
        woken = src;
        if (bus_valid && !src.ready && src.tag == bus_tag) begin
            woken.ready = 1'b1;
            woken.value = bus_value;
        end
        return woken;
    endfunction

endpackage

/* logic/stage_link.sv */
`timescale 1ns/100ps

// four-phase req/ack link, payload held stable while req is high
interface stage_link #(parameter type payload_t = logic);
    logic     req;
    logic     ack;
    payload_t payload;

    modport sender(output req, output payload, input ack);
    modport receiver(input req, input payload, output ack);
endinterface

// common result bus, one cycle per result
interface result_bus import issue_pkg::*; ();
    logic                  valid;
    logic [tag_width-1:0]  tag;
    logic [reg_width-1:0]  dest;
    logic [data_width-1:0] value;

    modport driver(output valid, output tag, output dest, output value);
    modport snoop(input valid, input tag, input dest, input value);
endinterface

/* logic/issue_select.sv */
`timescale 1ns/100ps

module issue_select import issue_pkg::*; (
    input  logic [rs_depth-1:0] request,
    output logic [rs_depth-1:0] grant,
    output logic                found
);

    // walk down so the lowest index is the last one written
    always_comb begin
        grant = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (request[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
            end
        end
    end

    assign found = |request;

endmodule

/* logic/dispatch_stage.sv */
`timescale 1ns/100ps

module dispatch_stage import issue_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        disp_req,
    output logic        disp_ack,
    input  instr_t      disp_instr,
    stage_link.sender   to_rs,
    result_bus.snoop    results
);

    stage_link #(.payload_t(instr_t)) front_link();

    logic [num_regs-1:0]                 reg_ready;
    logic [num_regs-1:0][tag_width-1:0]  reg_tag;
    logic [num_regs-1:0][data_width-1:0] reg_value;
    logic [tag_width-1:0]                next_tag;
    logic                                buf_valid;
    rs_entry_t                           buf_entry;
    rs_entry_t                           new_entry;
    logic                                accept;

    assign front_link.req     = disp_req;
    assign front_link.payload = disp_instr;
    assign disp_ack           = front_link.ack;

    assign accept        = front_link.req && !front_link.ack && !buf_valid;
    assign to_rs.payload = buf_entry;

    // rename both sources, picking up a result that arrives this cycle
    always_comb begin
        new_entry.valid      = 1'b1;
        new_entry.op         = front_link.payload.op;
        new_entry.dest       = front_link.payload.dest;
        new_entry.tag        = next_tag;
        new_entry.src1.ready = reg_ready[front_link.payload.src1];
        new_entry.src1.tag   = reg_tag[front_link.payload.src1];
        new_entry.src1.value = reg_value[front_link.payload.src1];
        new_entry.src2.ready = reg_ready[front_link.payload.src2];
        new_entry.src2.tag   = reg_tag[front_link.payload.src2];
        new_entry.src2.value = reg_value[front_link.payload.src2];
        new_entry.src1 = wake_operand(new_entry.src1, results.valid, results.tag, results.value);
        new_entry.src2 = wake_operand(new_entry.src2, results.valid, results.tag, results.value);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            front_link.ack <= 1'b0;
            to_rs.req      <= 1'b0;
            buf_valid      <= 1'b0;
            next_tag       <= '0;
            reg_ready      <= '1;
            reg_tag        <= '0;
            for (int i = 0; i < num_regs; i++) begin
                reg_value[i] <= reg_reset_value(i);
            end
        end else begin
            // only the latest producer of a register may clear it
            for (int i = 0; i < num_regs; i++) begin
                if (results.valid && !reg_ready[i] && reg_tag[i] == results.tag) begin
                    reg_ready[i] <= 1'b1;
                    reg_value[i] <= results.value;
                end
            end

            if (buf_valid) begin
                buf_entry.src1 <= wake_operand(buf_entry.src1, results.valid, results.tag,
                                               results.value);
                buf_entry.src2 <= wake_operand(buf_entry.src2, results.valid, results.tag,
                                               results.value);
            end

            if (accept) begin
                front_link.ack          <= 1'b1;
                buf_entry               <= new_entry;
                buf_valid               <= 1'b1;
                to_rs.req               <= 1'b1;
                reg_ready[new_entry.dest] <= 1'b0;
                reg_tag[new_entry.dest]   <= next_tag;
                next_tag                <= next_tag + 1'b1;
            end else if (!front_link.req) begin
                front_link.ack <= 1'b0;
            end

            if (to_rs.req && to_rs.ack) begin
                to_rs.req <= 1'b0;
            end

            // buffer frees once the station has dropped ack
            if (buf_valid && !to_rs.req && !to_rs.ack) begin
                buf_valid <= 1'b0;
            end
        end
    end

endmodule

/* logic/reservation_station.sv */
`timescale 1ns/100ps

module reservation_station import issue_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    stage_link.receiver  from_dispatch,
    result_bus.snoop     results,
    input  logic         alu_busy,
    output exec_op_t     issue_alu,
    output exec_op_t     issue_mult
);

    rs_entry_t [rs_depth-1:0] entries;
    rs_entry_t                incoming;
    logic [rs_depth-1:0]      alu_request;
    logic [rs_depth-1:0]      mult_request;
    logic [rs_depth-1:0]      alu_grant;
    logic [rs_depth-1:0]      mult_grant;
    logic                     alu_found;
    logic                     mult_found;
    logic [rs_depth-1:0]      free_slot;
    logic                     has_free;
    logic                     accept;

    function automatic exec_op_t to_exec(input rs_entry_t entry);
        exec_op_t op;
        op.valid      = 1'b1;
        op.op         = entry.op;
        op.dest       = entry.dest;
        op.tag        = entry.tag;
        op.src1_value = entry.src1.value;
        op.src2_value = entry.src2.value;
        return op;
    endfunction

    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            alu_request[i]  = entries[i].valid && entries[i].src1.ready &&
                              entries[i].src2.ready && entries[i].op != op_mul && !alu_busy;
            mult_request[i] = entries[i].valid && entries[i].src1.ready &&
                              entries[i].src2.ready && entries[i].op == op_mul;
        end
    end

    issue_select alu_select (
        .request (alu_request),
        .grant   (alu_grant),
        .found   (alu_found)
    );

    issue_select mult_select (
        .request (mult_request),
        .grant   (mult_grant),
        .found   (mult_found)
    );

    always_comb begin
        issue_alu  = '0;
        issue_mult = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (alu_found && alu_grant[i]) begin
                issue_alu = to_exec(entries[i]);
            end
            if (mult_found && mult_grant[i]) begin
                issue_mult = to_exec(entries[i]);
            end
        end
    end

    // lowest free slot, one-hot
    always_comb begin
        free_slot = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_slot    = '0;
                free_slot[i] = 1'b1;
            end
        end
    end

    assign has_free = |free_slot;
    assign accept   = from_dispatch.req && !from_dispatch.ack && has_free;

    always_comb begin
        incoming       = from_dispatch.payload;
        incoming.valid = 1'b1;
        incoming.src1  = wake_operand(incoming.src1, results.valid, results.tag, results.value);
        incoming.src2  = wake_operand(incoming.src2, results.valid, results.tag, results.value);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            from_dispatch.ack <= 1'b0;
            for (int i = 0; i < rs_depth; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                entries[i].src1 <= wake_operand(entries[i].src1, results.valid, results.tag,
                                                results.value);
                entries[i].src2 <= wake_operand(entries[i].src2, results.valid, results.tag,
                                                results.value);
                if (alu_grant[i] || mult_grant[i]) begin
                    entries[i].valid <= 1'b0;
                end
                if (accept && free_slot[i]) begin
                    entries[i] <= incoming;
                end
            end

            if (accept) begin
                from_dispatch.ack <= 1'b1;
            end else if (!from_dispatch.req) begin
                from_dispatch.ack <= 1'b0;
            end
        end
    end

endmodule

/* logic/exec_units.sv */
`timescale 1ns/100ps

module exec_units import issue_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  exec_op_t  issue_alu,
    input  exec_op_t  issue_mult,
    output logic      alu_busy,
    result_bus.driver results
);

    exec_op_t                                alu_op;
    logic [data_width-1:0]                   alu_result;
    logic [mult_stages-1:0]                  mult_valid;
    logic [mult_stages-1:0][tag_width-1:0]   mult_tag;
    logic [mult_stages-1:0][reg_width-1:0]   mult_dest;
    logic [mult_stages-1:0][data_width-1:0]  mult_product;

    always_comb begin
        case (alu_op.op)
            op_add:  alu_result = alu_op.src1_value + alu_op.src2_value;
            op_sub:  alu_result = alu_op.src1_value - alu_op.src2_value;
            op_and:  alu_result = alu_op.src1_value & alu_op.src2_value;
            op_xor:  alu_result = alu_op.src1_value ^ alu_op.src2_value;
            default: alu_result = '0;
        endcase
    end

    // an ALU issue now would meet this multiply on the bus
    assign alu_busy = mult_valid[1];

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_op.valid  <= 1'b0;
            mult_valid    <= '0;
            results.valid <= 1'b0;
        end else begin
            alu_op.valid  <= issue_alu.valid;
            mult_valid    <= {mult_valid[mult_stages-2:0], issue_mult.valid};
            results.valid <= mult_valid[mult_stages-1] || alu_op.valid;
        end
    end

    always_ff @(posedge clock) begin
        alu_op.op         <= issue_alu.op;
        alu_op.dest       <= issue_alu.dest;
        alu_op.tag        <= issue_alu.tag;
        alu_op.src1_value <= issue_alu.src1_value;
        alu_op.src2_value <= issue_alu.src2_value;

        // low half of the product, carried down the pipe
        mult_tag[0]     <= issue_mult.tag;
        mult_dest[0]    <= issue_mult.dest;
        mult_product[0] <= issue_mult.src1_value * issue_mult.src2_value;
        for (int i = 1; i < mult_stages; i++) begin
            mult_tag[i]     <= mult_tag[i-1];
            mult_dest[i]    <= mult_dest[i-1];
            mult_product[i] <= mult_product[i-1];
        end

        if (mult_valid[mult_stages-1]) begin
            results.tag   <= mult_tag[mult_stages-1];
            results.dest  <= mult_dest[mult_stages-1];
            results.value <= mult_product[mult_stages-1];
        end else begin
            results.tag   <= alu_op.tag;
            results.dest  <= alu_op.dest;
            results.value <= alu_result;
        end
    end

endmodule

/* logic/issue_core.sv */
`timescale 1ns/100ps

module issue_core import issue_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  disp_req,
    output logic                  disp_ack,
    input  op_t                   disp_op,
    input  logic [reg_width-1:0]  disp_dest,
    input  logic [reg_width-1:0]  disp_src1,
    input  logic [reg_width-1:0]  disp_src2,
    output logic                  result_valid,
    output logic [tag_width-1:0]  result_tag,
    output logic [reg_width-1:0]  result_dest,
    output logic [data_width-1:0] result_value
);

    stage_link #(.payload_t(rs_entry_t)) rs_link();
    result_bus results();

    instr_t   disp_instr;
    exec_op_t issue_alu;
    exec_op_t issue_mult;
    logic     alu_busy;

    assign disp_instr = '{op: disp_op, dest: disp_dest, src1: disp_src1, src2: disp_src2};

    dispatch_stage dispatch_stage_inst (
        .clock      (clock),
        .reset      (reset),
        .disp_req   (disp_req),
        .disp_ack   (disp_ack),
        .disp_instr (disp_instr),
        .to_rs      (rs_link.sender),
        .results    (results.snoop)
    );

    reservation_station reservation_station_inst (
        .clock         (clock),
        .reset         (reset),
        .from_dispatch (rs_link.receiver),
        .results       (results.snoop),
        .alu_busy      (alu_busy),
        .issue_alu     (issue_alu),
        .issue_mult    (issue_mult)
    );

    exec_units exec_units_inst (
        .clock      (clock),
        .reset      (reset),
        .issue_alu  (issue_alu),
        .issue_mult (issue_mult),
        .alu_busy   (alu_busy),
        .results    (results.driver)
    );

    assign result_valid = results.valid;
    assign result_tag   = results.tag;
    assign result_dest  = results.dest;
    assign result_value = results.value;

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
    output logic clock,
    output logic reset
);

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // held over the first five rising edges, released just after the fifth
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        #2 reset = 1'b0;
    end

endmodule

/* bench/issue_properties.sv */
`timescale 1ns/100ps

module issue_properties (
    input logic clock,
    input logic reset,
    input logic disp_req,
    input logic disp_ack,
    input logic result_valid
);

    logic reset_seen = 1'b0;
    int   failure_count = 0;

    always @(posedge clock) begin
        if (reset) begin
            reset_seen <= 1'b1;
        end
    end

    ack_rises_with_req: assert property (@(posedge clock) disable iff (reset)
        $rose(disp_ack) |-> $past(disp_req))
        else begin
            failure_count++;
            $error("disp_ack rose while disp_req was low");
        end

    ack_falls_without_req: assert property (@(posedge clock) disable iff (reset)
        $fell(disp_ack) |-> !$past(disp_req))
        else begin
            failure_count++;
            $error("disp_ack fell while disp_req was still high");
        end

    // first edge of reset has not cleared the registers yet
    outputs_low_in_reset: assert property (@(posedge clock)
        (reset && reset_seen) |-> (!disp_ack && !result_valid))
        else begin
            failure_count++;
            $error("disp_ack or result_valid high during reset");
        end

    result_valid_known: assert property (@(posedge clock)
        reset_seen |-> !$isunknown(result_valid))
        else begin
            failure_count++;
            $error("result_valid is unknown");
        end

endmodule

bind issue_core issue_properties issue_properties_inst (
    .clock        (clock),
    .reset        (reset),
    .disp_req     (disp_req),
    .disp_ack     (disp_ack),
    .result_valid (result_valid)
);

/* bench/issue_tb.sv */
`timescale 1ns/100ps

module issue_tb import issue_pkg::*; ();

    logic                  clock;
    logic                  reset;
    logic                  disp_req;
    logic                  disp_ack;
    op_t                   disp_op;
    logic [reg_width-1:0]  disp_dest;
    logic [reg_width-1:0]  disp_src1;
    logic [reg_width-1:0]  disp_src2;
    logic                  result_valid;
    logic [tag_width-1:0]  result_tag;
    logic [reg_width-1:0]  result_dest;
    logic [data_width-1:0] result_value;

    // one word per line: op, dest, src1, src2 nibbles then the 16-bit result
    logic [31:0]           golden [1 << tag_width];
    logic [data_width-1:0] exp_value [1 << tag_width];
    logic [reg_width-1:0]  exp_dest [1 << tag_width];
    logic                  seen [1 << tag_width];
    int                    num_lines = 0;
    int                    result_count = 0;
    int                    cycle_count = 0;
    int                    timeout_limit = 12 * (1 << tag_width) + 50;
    int                    seed = 15;

    clock_gen clock_gen_inst (
        .clock (clock),
        .reset (reset)
    );

    issue_core issue_core_inst (
        .clock        (clock),
        .reset        (reset),
        .disp_req     (disp_req),
        .disp_ack     (disp_ack),
        .disp_op      (disp_op),
        .disp_dest    (disp_dest),
        .disp_src1    (disp_src1),
        .disp_src2    (disp_src2),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_dest  (result_dest),
        .result_value (result_value)
    );

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, actual,
                                      expected));
        end
    endtask

    task automatic check_value(input logic [tag_width-1:0] tag,
                               input logic [data_width-1:0] actual,
                               input logic [data_width-1:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("ERROR result_value: tag 0x%h got 0x%h, expected 0x%h",
                                      tag, actual, expected));
        end
    endtask

    task automatic check_dest(input logic [tag_width-1:0] tag,
                              input logic [reg_width-1:0] actual,
                              input logic [reg_width-1:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("ERROR result_dest: tag 0x%h got 0x%h, expected 0x%h",
                                      tag, actual, expected));
        end
    endtask

    task automatic check_tag(input logic [tag_width-1:0] tag);
        if ($isunknown(tag) || tag >= num_lines) begin
            stop_with_error($sformatf("ERROR result_tag: 0x%h is not a dispatched tag", tag));
        end
        if (seen[tag]) begin
            stop_with_error($sformatf("ERROR result_tag: tag 0x%h reported twice", tag));
        end
    endtask

    // four-phase handshake, entered and left 2 ns after a rising edge
    task automatic send_instr(input int index);
        disp_req  = 1'b1;
        disp_op   = op_t'(golden[index][30:28]);
        disp_dest = golden[index][26:24];
        disp_src1 = golden[index][22:20];
        disp_src2 = golden[index][18:16];
        do begin
            @(posedge clock);
            #2;
        end while (!disp_ack);
        disp_req = 1'b0;
        do begin
            @(posedge clock);
            #2;
        end while (disp_ack);
    endtask

    always @(negedge clock) begin
        if (!reset && result_valid === 1'b1) begin
            check_tag(result_tag);
            check_dest(result_tag, result_dest, exp_dest[result_tag]);
            check_value(result_tag, result_value, exp_value[result_tag]);
            seen[result_tag] = 1'b1;
            result_count++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            stop_with_error($sformatf("timeout: %0d of %0d results after %0d cycles",
                                      result_count, num_lines, cycle_count));
        end
    end

    initial begin
        int gap;
        disp_req  = 1'b0;
        disp_op   = op_add;
        disp_dest = '0;
        disp_src1 = '0;
        disp_src2 = '0;
        for (int i = 0; i < $size(golden); i++) begin
            golden[i] = 'x;
            seen[i]   = 1'b0;
        end
        $readmemh("bench/issue_golden.txt", golden);
        while (num_lines < $size(golden) && !$isunknown(golden[num_lines])) begin
            exp_dest[num_lines]  = golden[num_lines][26:24];
            exp_value[num_lines] = golden[num_lines][15:0];
            num_lines++;
        end
        if (num_lines == 0) begin
            stop_with_error("no instructions could be read from the golden file");
        end
        timeout_limit = 12 * num_lines + 50;

        for (int c = 0; c < 5; c++) begin
            @(posedge clock);
            #1;
            check_flag("disp_ack", disp_ack, 1'b0);
            check_flag("result_valid", result_valid, 1'b0);
        end
        wait (!reset);

        for (int i = 0; i < num_lines; i++) begin
            send_instr(i);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) begin
                @(posedge clock);
                #2;
            end
        end

        wait (result_count == num_lines);
        // late or repeated results would show up here
        repeat (8) @(posedge clock);
        if (issue_core_inst.issue_properties_inst.failure_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_with_error($sformatf("%0d handshake or result bus assertions failed",
                                      issue_core_inst.issue_properties_inst.failure_count));
        end
    end

endmodule

/* bench/issue_golden.txt */
// columns: op_dest_src1_src2_result in hex, one instruction per line, tag = line number
// op: 0 add, 1 sub, 2 and, 3 xor, 4 mul (low 16 bits of the product)
0_1_2_3_0555
1_4_5_6_feef
2_0_7_3_0333
3_6_1_2_0777
4_2_1_4_505b
0_3_2_2_a0b6
3_5_0_7_0444
4_7_3_5_8858
4_1_7_7_9e40
0_0_1_6_a5b7
1_4_1_5_99fc
2_6_1_3_8000
3_2_1_0_3bf7
0_5_1_1_3c80
4_3_4_5_0e00
1_7_0_3_97b7

/* compile.f */
logic/issue_pkg.sv
logic/stage_link.sv
logic/issue_select.sv
logic/dispatch_stage.sv
logic/reservation_station.sv
logic/exec_units.sv
logic/issue_core.sv
bench/clock_gen.sv
bench/issue_properties.sv
bench/issue_tb.sv

/* Bender.yml */
package:
  name: issue_core

sources:
  - logic/issue_pkg.sv
  - logic/stage_link.sv
  - logic/issue_select.sv
  - logic/dispatch_stage.sv
  - logic/reservation_station.sv
  - logic/exec_units.sv
  - logic/issue_core.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/issue_properties.sv
      - bench/issue_tb.sv
